//--- Makefile
# Verilator build and run for the descriptor write-back engine

VERILATOR ?= verilator
TOP       ?= desc_store_tb
FILELIST  ?= desc_store.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/desc_store_tb.sv
`timescale 1ns/1ps
`include "desc_store_consts.svh"

module desc_store_tb;

  localparam int MAIN_BLOCKS   = 24;
  localparam int PHASE_RECORDS = 4;  // one block each in the disable and the flush test
  localparam int FIFO_DEPTH    = 1 << `DS_FIFO_DEPTH_LOG2;

  logic                        clk, reset, flush, enable_store, store_idle;
  logic                        m_write, m_waitrequest;
  logic [`DS_ADDR_WIDTH-1:0]   m_address, block_address;
  logic                        block_address_valid, block_address_ready;
  logic                        descriptor_valid, descriptor_ready;
  logic                        response_valid, response_ready;
  desc_store_pkg::writeback_t  m_writedata, held_data;
  desc_store_pkg::descriptor_t descriptor;
  desc_store_pkg::response_t   response;
  // sources still to be offered, then what the DUT has really taken in
  desc_store_pkg::descriptor_t desc_src_q[$], exp_desc_q[$];
  desc_store_pkg::response_t   resp_src_q[$], exp_resp_q[$];
  logic [`DS_ADDR_WIDTH-1:0]   blk_q[$];   // presented block addresses, oldest first
  logic [`DS_ADDR_WIDTH-1:0]   exp_addr, held_addr;
  logic [15:0]                 next_seq;
  logic                        stalled, allow_write, ready_seen;
  integer                      seed;
  int                          errors, checks, write_count, records_total;
  int                          cycle_count, cycle_limit, first_count, b;

  desc_store_top uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // record layout from the top bit down is padding, response, cleared owner bit, descriptor
  function automatic desc_store_pkg::writeback_t expected_record(
    input desc_store_pkg::descriptor_t d, input desc_store_pkg::response_t r);
    return {{(`DS_WB_WIDTH - 165){1'b0}}, r, 1'b0, d};
  endfunction

  // ******************************
  // compare tasks
  // ******************************
  task automatic check_record(input string name, input desc_store_pkg::writeback_t expected,
                              input desc_store_pkg::writeback_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_address(input string name, input logic [`DS_ADDR_WIDTH-1:0] expected,
                               input logic [`DS_ADDR_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at cycle %0d: %s", cycle_count, what);
  endtask

  // ******************************
  // stimulus generation
  // ******************************
  task automatic add_block_address();
    logic [`DS_ADDR_WIDTH-1:0] addr;
    addr      = $random(seed);
    addr[4:0] = '0;  // keeps every record on a beat boundary
    blk_q.push_back(addr);
  endtask

  task automatic add_records(input int size);
    desc_store_pkg::descriptor_t d;
    desc_store_pkg::response_t   r;
    int                          i;
    for (i = 0; i < size; i++)
    begin
      d.length            = $random(seed);
      d.destination       = $random(seed);
      d.source            = $random(seed);
      d.sequence_num      = next_seq;
      d.control           = 8'($random(seed));
      d.format            = {i == size - 1, 1'($random(seed))};  // last in block on the final one
      r.actual_bytes      = $random(seed);
      r.error             = 8'($random(seed));
      r.eop_arrived       = 1'($random(seed));
      r.early_termination = 1'($random(seed));
      next_seq            = next_seq + 16'd1;
      desc_src_q.push_back(d);
      resp_src_q.push_back(r);
    end
    records_total += size;  // the counts of descriptors and responses always match
  endtask

  // returns at a falling edge once everything offered has been written
  task automatic wait_drained();
    while (desc_src_q.size() > 0 || resp_src_q.size() > 0 ||
           exp_desc_q.size() > 0 || exp_resp_q.size() > 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  // random valids and waitrequest, the data always shows the head of each source
  always @(posedge clk)
  begin
    descriptor_valid    <= !reset && desc_src_q.size() > 0 && (($random(seed) & 1) != 0);
    response_valid      <= !reset && resp_src_q.size() > 0 && (($random(seed) & 1) != 0);
    m_waitrequest       <= ({$random(seed)} % 10) < 3;  // roughly 30 % of the cycles
    block_address_valid <= !reset && blk_q.size() > 0;
    if (desc_src_q.size() > 0)
      descriptor <= desc_src_q[0];
    if (resp_src_q.size() > 0)
      response <= resp_src_q[0];
    if (blk_q.size() > 0)
      block_address <= blk_q[0];
  end

  // ******************************
  // reference model, sampled where the outputs are settled
  // ******************************
  always @(negedge clk)
  begin
    if (!reset)
    begin
      // outstanding entries of the model are exactly what each FIFO holds right now
      check_flag("descriptor_ready", exp_desc_q.size() < FIFO_DEPTH, descriptor_ready);
      check_flag("response_ready", exp_resp_q.size() < FIFO_DEPTH, response_ready);
      if (stalled && m_write)  // a stalled beat must not change
      begin
        check_record("record held under waitrequest", held_data, m_writedata);
        check_address("address held under waitrequest", held_addr, m_address);
      end
      stalled   = m_write && m_waitrequest;
      held_data = m_writedata;
      held_addr = m_address;
      if (block_address_ready)
      begin
        check_flag("single ready pulse per block", 1'b0, ready_seen);
        check_flag("store_idle while loading", 1'b0, store_idle);
        if (blk_q.size() == 0)
          report_error("block_address_ready pulsed with no block address presented");
        else
          exp_addr = blk_q.pop_front();  // next block starts here
      end
      ready_seen = block_address_ready;
      if (m_write)
        check_flag("store_idle while writing", 1'b0, store_idle);
      if (m_write && !m_waitrequest)
      begin
        if (exp_desc_q.size() == 0 || exp_resp_q.size() == 0)
          report_error("write accepted with no outstanding descriptor and response");
        else
          check_record("write-back record", expected_record(exp_desc_q.pop_front(),
                       exp_resp_q.pop_front()), m_writedata);
        check_address("write address", exp_addr, m_address);
        exp_addr = exp_addr + `DS_WB_BYTES;
        write_count++;
      end
      if (!enable_store)  // only a write already on the bus may finish
      begin
        if (m_write && !allow_write)
          report_error("a new write started after enable_store fell");
        allow_write = m_write && m_waitrequest;
      end
      else
        allow_write = 1'b1;
      if (descriptor_valid && descriptor_ready)
        exp_desc_q.push_back(desc_src_q.pop_front());
      if (response_valid && response_ready)
        exp_resp_q.push_back(resp_src_q.pop_front());
      if (flush)
      begin
        exp_desc_q.delete();  // records from before the flush are gone
        exp_resp_q.delete();
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout after %0d cycles, the DUT stopped writing records", cycle_count);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Test FAILED");
      $finish;
    end
  end

  initial
  begin
    seed = 32'h8df;
    {errors, checks, write_count, records_total, cycle_count} = '0;
    cycle_limit = 2000;
    next_seq = '0;
    {stalled, ready_seen, exp_addr, held_addr, held_data} = '0;
    allow_write = 1'b1;
    reset = 1'b1;
    flush = 1'b0;
    enable_store = 1'b1;
    {descriptor_valid, response_valid, block_address_valid, m_waitrequest} = '0;
    descriptor = '0;
    response = '0;
    block_address = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // random blocks of 1 to 4 records back to back
    @(negedge clk);
    for (b = 0; b < MAIN_BLOCKS; b++)
    begin
      add_block_address();
      add_records(1 + ({$random(seed)} % 4));
    end
    cycle_limit = 20 * (records_total + 2 * PHASE_RECORDS) + 2000;
    wait_drained();
    check_flag("store_idle after the last block", 1'b1, store_idle);
    check_flag("every block address consumed", 1'b1, blk_q.size() == 0);
    // disable the engine right after the first record of a block
    add_block_address();
    add_records(PHASE_RECORDS);
    first_count = write_count;
    while (write_count == first_count)
      @(posedge clk);
    enable_store <= 1'b0;
    while (desc_src_q.size() > 0 || resp_src_q.size() > 0)
      @(posedge clk);
    repeat (10) @(posedge clk);
    check_flag("store_idle after disable", 1'b1, store_idle);
    flush <= 1'b1;  // drops the rest of the interrupted block
    @(posedge clk);
    flush        <= 1'b0;
    enable_store <= 1'b1;
    // a block address alone must not bring back any old record
    @(negedge clk);
    add_block_address();
    first_count = write_count;
    repeat (20) @(posedge clk);
    check_flag("no write after flush", 1'b1, write_count == first_count);
    @(negedge clk);
    add_records(PHASE_RECORDS);
    wait_drained();
    check_flag("store_idle after the flush test", 1'b1, store_idle);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- desc_store.f
+incdir+hdl
hdl/desc_store_pkg.sv
hdl/store_if.sv
hdl/desc_fifo.sv
hdl/block_sequencer.sv
hdl/writeback_master.sv
hdl/desc_store_top.sv
bench/desc_store_tb.sv

//--- hdl/block_sequencer.sv
`timescale 1ns/1ps
`include "desc_store_consts.svh"

// walks the write address through each descriptor block
module block_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      enable_store,
  input  logic [`DS_ADDR_WIDTH-1:0] block_address,
  input  logic                      block_address_valid,
  output logic                      block_address_ready,
  output logic                      store_idle,
  input  logic                      write_pending,  // the master's m_write
  store_if.sequencer                st
);

  localparam logic [`DS_ADDR_WIDTH-1:0] ADDR_STEP = `DS_WB_BYTES;

  logic [1:0]                state;
  logic [1:0]                state_next;
  logic [`DS_ADDR_WIDTH-1:0] address_counter;
  logic                      stop_ok;

  // ******************************
  // state machine
  // ******************************
  // idle -> load -> store, and store goes back to load or idle at the end of a block

  // stopping is only safe at a beat boundary
  assign stop_ok = !write_pending || st.beat_done;

  always_comb
  begin
    state_next = state;
    if (!enable_store && stop_ok)
    begin
      state_next = `DS_STATE_IDLE;  // an open write is let through before stopping
    end
    else
    begin
      case (state)
        `DS_STATE_IDLE:
          if (block_address_valid)
            state_next = `DS_STATE_LOAD;
        `DS_STATE_LOAD:
          state_next = `DS_STATE_STORE;  // single cycle, the counter is loaded here
        `DS_STATE_STORE:
          if (st.last_beat)
            state_next = block_address_valid ? `DS_STATE_LOAD : `DS_STATE_IDLE;
        default:
          state_next = `DS_STATE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset || flush)
      state <= `DS_STATE_IDLE;
    else
      state <= state_next;
  end

  // ******************************
  // descriptor address counter
  // ******************************
  always_ff @(posedge clk)
  begin
    if (state == `DS_STATE_LOAD)
      address_counter <= block_address;  // start of the next block
    else if (st.beat_done)
      address_counter <= address_counter + ADDR_STEP;  // one record per beat
  end

  assign block_address_ready = (state == `DS_STATE_LOAD);  // pops the block address source
  assign store_idle          = (state == `DS_STATE_IDLE);
  assign st.storing          = (state == `DS_STATE_STORE);
  assign st.address          = address_counter;

  // the block address source has to keep valid high until its ready pulse
  a_block_addr_held: assert property (@(posedge clk) disable iff (reset)
    block_address_ready |-> block_address_valid);

endmodule

//--- hdl/desc_fifo.sv
`timescale 1ns/1ps
`include "desc_store_consts.svh"

// show-ahead FIFO, head always presents the oldest entry without a read request
module desc_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  payload_t push_data,
  input  logic     push_valid,
  output logic     push_ready,
  output payload_t head,
  output logic     empty,
  input  logic     pop
);

  localparam logic [`DS_FIFO_DEPTH_LOG2:0] DEPTH = 1 << `DS_FIFO_DEPTH_LOG2;

  payload_t                       mem [0:DEPTH-1];
  logic [`DS_FIFO_DEPTH_LOG2-1:0] wr_ptr;  // wraps naturally since the depth is a power of two
  logic [`DS_FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [`DS_FIFO_DEPTH_LOG2:0]   count;   // one extra bit to tell full from empty
  logic                           full;
  logic                           push;

  assign full       = (count == DEPTH);
  assign empty      = (count == '0);
  assign push_ready = !full;
  assign push       = push_valid && push_ready;  // a transfer needs both sides
  assign head       = mem[rd_ptr];               // visible one edge after the write

  // ******************************
  // pointers and occupancy
  // ******************************
  always_ff @(posedge clk)
  begin
    if (reset || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;  // stale entries simply become unreachable
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop cancel out
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // the consumer only pops a head that is really there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

  // a push never lands on the slot of the unread head
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    push |-> (empty || wr_ptr != rd_ptr));

endmodule

//--- hdl/desc_store_consts.svh
`ifndef DESC_STORE_CONSTS_SVH
`define DESC_STORE_CONSTS_SVH

// width of the memory write address and of every block address
`define DS_ADDR_WIDTH 32

// both FIFOs hold 2**3 entries
`define DS_FIFO_DEPTH_LOG2 3

// one write-back record fills exactly one 256 bit beat
`define DS_WB_WIDTH 256
`define DS_WB_BYTES 32     // address step from one record to the next

// ******************************
// sequencer state encodings
// ******************************
`define DS_STATE_IDLE  2'b00   // waiting for a block address or disabled
`define DS_STATE_LOAD  2'b01   // one cycle, loads the address counter
`define DS_STATE_STORE 2'b10   // writing records of the current block

`endif

//--- hdl/desc_store_pkg.sv
`include "desc_store_consts.svh"

package desc_store_pkg;

  // ******************************
  // descriptor as issued to the dispatcher
  // ******************************
  // only the fields that the store path writes back are carried
  typedef struct packed {
    logic [31:0] length;
    logic [31:0] destination;
    logic [31:0] source;
    logic [15:0] sequence_num;  // lets software match records to requests
    logic [7:0]  control;
    logic [1:0]  format;        // bit 1 marks the last descriptor of a block
  } descriptor_t;               // 122 bits

  // completion status returned by the dispatcher
  typedef struct packed {
    logic        early_termination;
    logic        eop_arrived;
    logic [7:0]  error;
    logic [31:0] actual_bytes;  // bytes really moved, may be short of length
  } response_t;                 // 42 bits

  // ******************************
  // merged record written back to host memory
  // ******************************
  // 122 descriptor bits, one ownership bit and 42 response bits leave 91 bits of padding
  typedef struct packed {
    logic [`DS_WB_WIDTH-166:0] reserved;  // always zero on the bus
    logic        early_termination;
    logic        eop_arrived;
    logic [7:0]  error;
    logic [31:0] actual_bytes;
    logic        owned_by_hw;            // cleared so software can reuse the slot
    logic [31:0] length;
    logic [31:0] destination;
    logic [31:0] source;
    logic [15:0] sequence_num;
    logic [7:0]  control;
    logic [1:0]  format;
  } writeback_t;

endpackage

//--- hdl/desc_store_top.sv
`timescale 1ns/1ps
`include "desc_store_consts.svh"

module desc_store_top (
  input  logic                        clk,
  input  logic                        reset,
  output logic [`DS_ADDR_WIDTH-1:0]   m_address,
  output logic                        m_write,
  output desc_store_pkg::writeback_t  m_writedata,
  input  logic                        m_waitrequest,
  input  logic [`DS_ADDR_WIDTH-1:0]   block_address,
  input  logic                        block_address_valid,
  output logic                        block_address_ready,
  input  desc_store_pkg::descriptor_t descriptor,
  input  logic                        descriptor_valid,
  output logic                        descriptor_ready,
  input  desc_store_pkg::response_t   response,
  input  logic                        response_valid,
  output logic                        response_ready,
  input  logic                        enable_store,
  input  logic                        flush,
  output logic                        store_idle
);

  desc_store_pkg::descriptor_t desc_head;
  desc_store_pkg::response_t   resp_head;
  logic                        desc_empty;
  logic                        resp_empty;
  logic                        pop;  // one accepted beat retires a head from each FIFO

  store_if st_bus (.clk(clk));

  // ******************************
  // issued descriptors and their completions
  // ******************************
  desc_fifo #(.payload_t(desc_store_pkg::descriptor_t)) u_desc_fifo (
    .clk(clk), .reset(reset), .flush(flush),
    .push_data(descriptor), .push_valid(descriptor_valid), .push_ready(descriptor_ready),
    .head(desc_head), .empty(desc_empty), .pop(pop)
  );

  desc_fifo #(.payload_t(desc_store_pkg::response_t)) u_resp_fifo (
    .clk(clk), .reset(reset), .flush(flush),
    .push_data(response), .push_valid(response_valid), .push_ready(response_ready),
    .head(resp_head), .empty(resp_empty), .pop(pop)
  );

  block_sequencer u_seq (
    .clk(clk), .reset(reset), .flush(flush), .enable_store(enable_store),
    .block_address(block_address), .block_address_valid(block_address_valid),
    .block_address_ready(block_address_ready), .store_idle(store_idle),
    .write_pending(m_write), .st(st_bus.sequencer)
  );

  writeback_master u_master (
    .desc_head(desc_head), .desc_empty(desc_empty),
    .resp_head(resp_head), .resp_empty(resp_empty), .pop(pop),
    .m_address(m_address), .m_write(m_write), .m_writedata(m_writedata),
    .m_waitrequest(m_waitrequest), .st(st_bus.master)
  );

endmodule

//--- hdl/store_if.sv
`timescale 1ns/1ps
`include "desc_store_consts.svh"

// links the block sequencer to the write-back master
interface store_if (
  input logic clk              // sampled by the checks on the master side
);

  logic                      storing;    // sequencer sits in STORE
  logic [`DS_ADDR_WIDTH-1:0] address;    // where the next record goes
  logic                      beat_done;  // a write was accepted this cycle
  logic                      last_beat;  // and it carried the last record of the block

  modport sequencer (
    output storing,
    output address,
    input  beat_done,
    input  last_beat
  );

  modport master (
    input  clk,
    input  storing,
    input  address,
    output beat_done,
    output last_beat
  );

endinterface

//--- hdl/writeback_master.sv
`timescale 1ns/1ps
`include "desc_store_consts.svh"

// merges the two FIFO heads into one record and writes it in a single beat
module writeback_master (
  input  desc_store_pkg::descriptor_t desc_head,
  input  logic                        desc_empty,
  input  desc_store_pkg::response_t   resp_head,
  input  logic                        resp_empty,
  output logic                        pop,
  output logic [`DS_ADDR_WIDTH-1:0]   m_address,
  output logic                        m_write,
  output desc_store_pkg::writeback_t  m_writedata,
  input  logic                        m_waitrequest,
  store_if.master                     st
);

  // ******************************
  // record merge
  // ******************************
  always_comb
  begin
    m_writedata                   = '0;  // padding bits go out as zero
    m_writedata.format            = desc_head.format;
    m_writedata.control           = desc_head.control;
    m_writedata.sequence_num      = desc_head.sequence_num;
    m_writedata.source            = desc_head.source;
    m_writedata.destination       = desc_head.destination;
    m_writedata.length            = desc_head.length;
    m_writedata.owned_by_hw       = 1'b0;  // hands the descriptor back to software
    m_writedata.actual_bytes      = resp_head.actual_bytes;
    m_writedata.error             = resp_head.error;
    m_writedata.eop_arrived       = resp_head.eop_arrived;
    m_writedata.early_termination = resp_head.early_termination;
  end

  // a record needs both its descriptor and its response
  assign m_write      = st.storing && !desc_empty && !resp_empty;
  assign m_address    = st.address;
  assign st.beat_done = m_write && !m_waitrequest;  // accepted this cycle
  assign st.last_beat = st.beat_done && desc_head.format[1];
  assign pop          = st.beat_done;  // retires both heads together

  // nothing is popped under waitrequest so the beat holds until accepted
  // m_write can only drop here through flush or reset
  a_hold_beat: assert property (@(posedge st.clk)
    (m_write && m_waitrequest) |=>
      (!m_write || ($stable(m_writedata) && $stable(m_address))));

endmodule
